//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
logic/cpu_isa_pkg.sv
logic/cpu_ctrl_pkg.sv
logic/instr_decoder.sv
logic/control_fsm.sv
logic/reg_file.sv
logic/datapath.sv
logic/cpu.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

//--- dv/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker #(
    parameter int ADDR_W = cpu_isa_pkg::MEM_ADDR_W
) (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_ctrl_pkg::mem_cmd_t mem_cmd,
    input  logic [ADDR_W-1:0]      mem_addr,
    input  cpu_isa_pkg::word_t     write_data,
    input  logic                   n,
    input  logic                   v,
    input  logic                   z,
    input  logic                   halted,
    output int                     errors,
    output int                     checks
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    localparam int MAX_STEPS = 4 * (1 << ADDR_W);

    word_t             mem [1 << ADDR_W];
    word_t             regs [NUM_REGS];
    logic [ADDR_W-1:0] exp_addr [$];
    word_t             exp_data [$];
    logic              flag_n, flag_v, flag_z;
    bit                cmp_seen = 1'b0;
    bit                first_read_seen = 1'b0;
    bit                halt_seen = 1'b0;
    int                err_count = 0;
    int                check_count = 0;
    int                store_idx = 0;

    assign errors = err_count;
    assign checks = check_count;

    task automatic set_word(input logic [ADDR_W-1:0] a, input word_t w);
        mem[a] = w;
    endtask

    function automatic word_t shift_model(input word_t x, input logic [1:0] sh);
        case (sh)
            2'b01:   return x << 1;
            2'b10:   return x >> 1;
            2'b11:   return word_t'($signed(x) >>> 1);   // keeps the sign
            default: return x;
        endcase
    endfunction

    // runs the whole program once and records stores and flags
    task automatic run_model();
        word_t             w, a, b, res, ea, imm5, imm8;
        logic [2:0]        opc, rn, rd, rm;
        logic [1:0]        op, sh;
        logic [ADDR_W-1:0] pc;
        int                steps, diff;
        bit                done;
        pc = '0;
        steps = 0;
        done = 1'b0;
        for (int r = 0; r < NUM_REGS; r++) begin
            regs[r] = '0;
        end
        while (!done && steps < MAX_STEPS) begin
            w    = mem[pc];
            pc   = pc + 1'b1;
            opc  = w[15:13];
            op   = w[12:11];
            rn   = w[10:8];
            rd   = w[7:5];
            sh   = w[4:3];
            rm   = w[2:0];
            imm5 = {{11{w[4]}}, w[4:0]};
            imm8 = {{8{w[7]}}, w[7:0]};
            ea   = regs[rn] + imm5;
            case (opc)
                OPC_MOV: begin
                    if (op == 2'b10) begin
                        regs[rn] = imm8;
                    end else if (op == 2'b00) begin
                        regs[rd] = shift_model(regs[rm], sh);
                    end
                end
                OPC_ALU: begin
                    a = regs[rn];
                    b = shift_model(regs[rm], sh);
                    case (op)
                        2'b00: regs[rd] = a + b;
                        2'b01: begin
                            res      = a - b;
                            diff     = int'($signed(a)) - int'($signed(b));
                            flag_n   = res[15];
                            flag_z   = (res == 16'h0000);
                            flag_v   = (diff > 32767) || (diff < -32768);
                            cmp_seen = 1'b1;
                        end
                        2'b10: regs[rd] = a & b;
                        default: regs[rd] = ~b;
                    endcase
                end
                OPC_LDR: begin
                    if (op == 2'b00) begin
                        regs[rd] = mem[ea[ADDR_W-1:0]];
                    end
                end
                OPC_STR: begin
                    if (op == 2'b00) begin
                        mem[ea[ADDR_W-1:0]] = regs[rd];
                        exp_addr.push_back(ea[ADDR_W-1:0]);
                        exp_data.push_back(regs[rd]);
                    end
                end
                OPC_HALT: done = 1'b1;
                default: ;   // undefined opcode skipped
            endcase
            steps++;
        end
        if (!done) begin
            err_count++;
            $display("the program model ran %0d steps without reaching HALT", steps);
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            check_count++;
            if (mem_cmd !== MEM_NONE || halted !== 1'b0) begin
                err_count++;
                $display("ERR %0t: in reset mem_cmd %0d halted %b", $time, mem_cmd, halted);
            end
        end else if (!halt_seen) begin
            if (!first_read_seen && mem_cmd == MEM_READ) begin
                first_read_seen = 1'b1;
                check_count++;
                if (mem_addr !== '0) begin
                    err_count++;
                    $display("ERR %0t: first fetch from %h, expected 0", $time, mem_addr);
                end
            end
            if (mem_cmd == MEM_WRITE) begin
                check_count++;
                if (exp_addr.size() == 0) begin
                    err_count++;
                    $display("ERR %0t: extra store of %h to %h", $time, write_data, mem_addr);
                end else begin
                    if (mem_addr !== exp_addr[0] || write_data !== exp_data[0]) begin
                        err_count++;
                        $display("ERR %0t: store %0d wrote %h to %h, expected %h to %h",
                                 $time, store_idx, write_data, mem_addr,
                                 exp_data[0], exp_addr[0]);
                    end
                    exp_addr.delete(0);
                    exp_data.delete(0);
                    store_idx++;
                end
            end
            if (halted === 1'b1) begin
                halt_seen = 1'b1;
                check_count++;
                if (exp_addr.size() != 0) begin
                    err_count++;
                    $display("the processor halted with %0d stores still missing",
                             exp_addr.size());
                end
                if (cmp_seen && {n, v, z} !== {flag_n, flag_v, flag_z}) begin
                    err_count++;
                    $display("ERR %0t: flags nvz %b%b%b, expected %b%b%b",
                             $time, n, v, z, flag_n, flag_v, flag_z);
                end
            end
        end else begin
            if (mem_cmd !== MEM_NONE) begin
                err_count++;
                $display("memory command %0d was issued after halt", mem_cmd);
            end
            if (halted !== 1'b1) begin
                err_count++;
                $display("halted dropped without a reset");
            end
        end
    end

endmodule

//--- dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    localparam int ADDR_W     = 9;
    localparam int MEM_WORDS  = 1 << ADDR_W;
    localparam int N_RANDOM   = 40;
    localparam int PROG_LEN   = 2 * NUM_REGS + N_RANDOM + 1;   // movs, random, stores, halt
    localparam int MAX_CYCLES = 9 * PROG_LEN + 100;

    logic              clk;
    logic              rst;
    word_t             read_data = '0;
    word_t             write_data;
    mem_cmd_t          mem_cmd;
    logic [ADDR_W-1:0] mem_addr;
    logic              n;
    logic              v;
    logic              z;
    logic              halted;
    int                errors;
    int                checks;
    int                cycles;

    word_t             mem [MEM_WORDS];
    logic [31:0]       lfsr = 32'h0d04_78aa;
    logic              rd_pending = 1'b0;
    logic [ADDR_W-1:0] rd_addr = '0;

    cpu #(.ADDR_W(ADDR_W)) cpu_i (
        .clk        (clk),
        .rst        (rst),
        .read_data  (read_data),
        .mem_cmd    (mem_cmd),
        .mem_addr   (mem_addr),
        .write_data (write_data),
        .n          (n),
        .v          (v),
        .z          (z),
        .halted     (halted)
    );

    cpu_checker #(.ADDR_W(ADDR_W)) chk (
        .clk        (clk),
        .rst        (rst),
        .mem_cmd    (mem_cmd),
        .mem_addr   (mem_addr),
        .write_data (write_data),
        .n          (n),
        .v          (v),
        .z          (z),
        .halted     (halted),
        .errors     (errors),
        .checks     (checks)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int count, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < count; i++) begin
            val = {val[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic word_t fill_word(input logic [ADDR_W-1:0] a);
        return (word_t'(a) * 16'h9e37) ^ 16'h5ac3;
    endfunction

    function automatic word_t reg_word(input logic [2:0] opc, input logic [1:0] op,
                                       input logic [2:0] rn, input logic [2:0] rd,
                                       input logic [1:0] sh, input logic [2:0] rm);
        return {opc, op, rn, rd, sh, rm};
    endfunction

    function automatic word_t imm5_word(input logic [2:0] opc, input logic [2:0] rn,
                                        input logic [2:0] rd, input logic [4:0] imm5);
        return {opc, 2'b00, rn, rd, imm5};
    endfunction

    function automatic word_t imm8_word(input logic [2:0] rn, input logic [7:0] imm8);
        return {OPC_MOV, OP_MOV_IMM, rn, imm8};
    endfunction

    task automatic build_program();
        logic [ADDR_W-1:0] pc;
        logic [7:0]        kind, rn, rd, rm, sh, imm;
        logic [2:0]        dest;
        pc = '0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a[ADDR_W-1:0]] = fill_word(a[ADDR_W-1:0]);
        end
        for (int r = 0; r < NUM_REGS - 1; r++) begin
            take_bits(8, imm);
            mem[pc] = imm8_word(r[2:0], imm);
            pc = pc + 1'b1;
        end
        take_bits(6, imm);
        mem[pc] = imm8_word(3'd7, {2'b10, imm[5:0]});   // r7 base with low bits 384..447
        pc = pc + 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            take_bits(3, kind);
            take_bits(3, rn);
            take_bits(3, rd);
            take_bits(3, rm);
            take_bits(2, sh);
            take_bits(8, imm);
            dest = (rd[2:0] == 3'd7) ? 3'd6 : rd[2:0];   // never overwrite the base
            case (kind[2:0])
                3'd0: mem[pc] = imm8_word(dest, imm);
                3'd1: mem[pc] = reg_word(OPC_MOV, OP_MOV_REG, 3'd0, dest, sh[1:0], rm[2:0]);
                3'd2: mem[pc] = reg_word(OPC_ALU, ALU_ADD, rn[2:0], dest, sh[1:0], rm[2:0]);
                3'd3: mem[pc] = reg_word(OPC_ALU, ALU_SUB, rn[2:0], dest, sh[1:0], rm[2:0]);
                3'd4: mem[pc] = reg_word(OPC_ALU, ALU_AND, rn[2:0], dest, sh[1:0], rm[2:0]);
                3'd5: mem[pc] = reg_word(OPC_ALU, ALU_NOT_B, 3'd0, dest, sh[1:0], rm[2:0]);
                3'd6: mem[pc] = imm5_word(OPC_LDR, 3'd7, dest, imm[4:0]);
                default: mem[pc] = imm5_word(OPC_STR, 3'd7, rd[2:0], imm[4:0]);
            endcase
            pc = pc + 1'b1;
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            mem[pc] = imm5_word(OPC_STR, 3'd7, r[2:0], r[4:0]);   // dump r at base + r
            pc = pc + 1'b1;
        end
        mem[pc] = {OPC_HALT, 13'd0};
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // memory model with read data one cycle after the request
    always @(negedge clk) begin
        if (rd_pending) begin
            read_data = mem[rd_addr];
        end
        rd_pending = (mem_cmd == MEM_READ);
        rd_addr    = mem_addr;
        if (mem_cmd == MEM_WRITE) begin
            mem[mem_addr] = write_data;
        end
    end

    initial begin
        rst = 1'b1;
        build_program();
        for (int a = 0; a < MEM_WORDS; a++) begin
            chk.set_word(a[ADDR_W-1:0], mem[a[ADDR_W-1:0]]);
        end
        chk.run_model();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        cycles = 0;
        while (halted !== 1'b1 && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (halted === 1'b1) begin
            repeat (10) @(negedge clk);   // watch the bus after halt
        end
        @(posedge clk);   // checker samples on the falling edge
        $display("checks %0d, errors %0d", checks, errors);
        if (halted !== 1'b1) begin
            $display("timeout after %0d cycles, the processor never halted", cycles);
            $display("Simulation FAILED");
        end else if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- logic/control_fsm.sv
`timescale 1ns/1ps

module control_fsm (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_isa_pkg::opcode_t   opcode,
    input  cpu_isa_pkg::alu_op_t   op,
    output cpu_ctrl_pkg::reg_sel_t reg_sel,
    output cpu_ctrl_pkg::wb_sel_t  wb_sel,
    output logic                   reg_write,
    output logic                   load_a,
    output logic                   load_b,
    output logic                   load_c,
    output logic                   load_status,
    output logic                   asel_zero,
    output logic                   bsel_imm,
    output logic                   pc_load,
    output logic                   pc_clear,
    output logic                   ir_load,
    output logic                   addr_sel_pc,
    output logic                   addr_load,
    output cpu_ctrl_pkg::mem_cmd_t mem_cmd,
    output logic                   halted
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = ST_FETCH_REQ;   // most paths end back at fetch
        case (state)
            ST_RESET:      state_next = ST_FETCH_REQ;
            ST_FETCH_REQ:  state_next = ST_FETCH_LOAD;
            ST_FETCH_LOAD: state_next = ST_PC_INC;
            ST_PC_INC:     state_next = ST_DECODE;
            ST_DECODE: begin
                case (opcode)
                    OPC_MOV: state_next = (op == OP_MOV_IMM) ? ST_MOV_IMM :
                                          (op == OP_MOV_REG) ? ST_MOV_LOAD_B : ST_FETCH_REQ;
                    OPC_ALU: state_next = (op == ALU_NOT_B) ? ST_MVN_LOAD_B : ST_ALU_LOAD_A;
                    OPC_LDR: state_next = (op == ALU_ADD) ? ST_LDR_LOAD_A : ST_FETCH_REQ;
                    OPC_STR: state_next = (op == ALU_ADD) ? ST_STR_LOAD_A : ST_FETCH_REQ;
                    OPC_HALT: state_next = ST_HALT;
                    default: state_next = ST_FETCH_REQ;   // undefined opcode
                endcase
            end
            ST_MOV_LOAD_B: state_next = ST_MOV_SHIFT;
            ST_MOV_SHIFT:  state_next = ST_MOV_WRITE;
            ST_ALU_LOAD_A: state_next = ST_ALU_LOAD_B;
            ST_ALU_LOAD_B: state_next = (op == ALU_SUB) ? ST_CMP : ST_ALU_EXEC;
            ST_ALU_EXEC:   state_next = ST_ALU_WRITE;
            ST_MVN_LOAD_B: state_next = ST_MVN_EXEC;
            ST_MVN_EXEC:   state_next = ST_MVN_WRITE;
            ST_LDR_LOAD_A: state_next = ST_LDR_CALC;
            ST_LDR_CALC:   state_next = ST_LDR_ADDR;
            ST_LDR_ADDR:   state_next = ST_LDR_WAIT;
            ST_LDR_WAIT:   state_next = ST_LDR_WB;
            ST_STR_LOAD_A: state_next = ST_STR_CALC;
            ST_STR_CALC:   state_next = ST_STR_ADDR;
            ST_STR_ADDR:   state_next = ST_STR_PASS;
            ST_STR_PASS:   state_next = ST_STR_WRITE;
            ST_HALT:       state_next = ST_HALT;   // held until reset
            default:       state_next = ST_FETCH_REQ;
        endcase
    end

    always_comb begin
        reg_sel     = SEL_RN;
        wb_sel      = WB_C;
        reg_write   = 1'b0;
        load_a      = 1'b0;
        load_b      = 1'b0;
        load_c      = 1'b0;
        load_status = 1'b0;
        asel_zero   = 1'b0;
        bsel_imm    = 1'b0;
        pc_load     = 1'b0;
        pc_clear    = 1'b0;
        ir_load     = 1'b0;
        addr_sel_pc = 1'b0;
        addr_load   = 1'b0;
        mem_cmd     = MEM_NONE;
        halted      = 1'b0;
        case (state)
            ST_RESET: begin
                pc_clear = 1'b1;
            end
            ST_FETCH_REQ: begin
                addr_sel_pc = 1'b1;
                mem_cmd     = MEM_READ;
            end
            ST_FETCH_LOAD: begin
                addr_sel_pc = 1'b1;
                mem_cmd     = MEM_READ;
                ir_load     = 1'b1;   // word from the request cycle
            end
            ST_PC_INC: begin
                pc_load = 1'b1;
            end
            ST_MOV_IMM: begin
                wb_sel    = WB_IMM8;
                reg_write = 1'b1;
            end
            ST_ALU_LOAD_A, ST_LDR_LOAD_A, ST_STR_LOAD_A: begin
                load_a = 1'b1;
            end
            ST_MOV_LOAD_B, ST_ALU_LOAD_B, ST_MVN_LOAD_B: begin
                reg_sel = SEL_RM;
                load_b  = 1'b1;
            end
            ST_MOV_SHIFT, ST_STR_PASS: begin
                asel_zero = 1'b1;   // 0 + shifted B
                load_c    = 1'b1;
            end
            ST_ALU_EXEC, ST_MVN_EXEC: begin
                load_c = 1'b1;
            end
            ST_CMP: begin
                load_status = 1'b1;
            end
            ST_MOV_WRITE, ST_ALU_WRITE, ST_MVN_WRITE: begin
                reg_sel   = SEL_RD;
                reg_write = 1'b1;
            end
            ST_LDR_CALC, ST_STR_CALC: begin
                bsel_imm = 1'b1;   // base + sximm5
                load_c   = 1'b1;
            end
            ST_LDR_ADDR: begin
                addr_load = 1'b1;
            end
            ST_LDR_WAIT: begin
                mem_cmd = MEM_READ;
            end
            ST_LDR_WB: begin
                reg_sel   = SEL_RD;
                wb_sel    = WB_MEM;
                reg_write = 1'b1;
            end
            ST_STR_ADDR: begin
                addr_load = 1'b1;
                reg_sel   = SEL_RD;   // store data into B
                load_b    = 1'b1;
            end
            ST_STR_WRITE: begin
                mem_cmd = MEM_WRITE;
            end
            ST_HALT: begin
                halted = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // a store must go to the data address, never over an instruction fetch
    a_no_write_on_pc: assert property (
        @(posedge clk) disable iff (rst) !(mem_cmd == MEM_WRITE && addr_sel_pc)
    );

    // C feeds write-back, so it may not change in the write cycle
    a_no_write_with_load_c: assert property (
        @(posedge clk) disable iff (rst) !(reg_write && load_c)
    );

endmodule

//--- logic/cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter int ADDR_W = cpu_isa_pkg::MEM_ADDR_W
) (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_isa_pkg::word_t     read_data,
    output cpu_ctrl_pkg::mem_cmd_t mem_cmd,
    output logic [ADDR_W-1:0]      mem_addr,
    output cpu_isa_pkg::word_t     write_data,
    output logic                   n,
    output logic                   v,
    output logic                   z,
    output logic                   halted
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] data_addr;
    word_t             ir;

    opcode_t  opcode;
    alu_op_t  op;
    shift_t   shift;
    word_t    sximm8;
    word_t    sximm5;
    reg_num_t reg_num;
    reg_sel_t reg_sel;
    wb_sel_t  wb_sel;
    word_t    reg_data;
    word_t    wb_data;
    word_t    c_out;

    logic reg_write;
    logic load_a;
    logic load_b;
    logic load_c;
    logic load_status;
    logic asel_zero;
    logic bsel_imm;
    logic pc_load;
    logic pc_clear;
    logic ir_load;
    logic addr_sel_pc;
    logic addr_load;

    if (ADDR_W > WORD_W) begin : g_addr_check
        $error("address wider than the data word");
    end

    always_ff @(posedge clk) begin
        if (pc_clear) begin
            pc <= '0;
        end else if (pc_load) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_load) begin
            ir <= read_data;
        end
        if (addr_load) begin
            data_addr <= c_out[ADDR_W-1:0];   // base + offset from C
        end
    end

    assign mem_addr   = addr_sel_pc ? pc : data_addr;
    assign write_data = c_out;

    instr_decoder u_decoder (
        .instr   (ir),
        .reg_sel (reg_sel),
        .opcode  (opcode),
        .op      (op),
        .shift   (shift),
        .sximm8  (sximm8),
        .sximm5  (sximm5),
        .reg_num (reg_num)
    );

    control_fsm u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .opcode      (opcode),
        .op          (op),
        .reg_sel     (reg_sel),
        .wb_sel      (wb_sel),
        .reg_write   (reg_write),
        .load_a      (load_a),
        .load_b      (load_b),
        .load_c      (load_c),
        .load_status (load_status),
        .asel_zero   (asel_zero),
        .bsel_imm    (bsel_imm),
        .pc_load     (pc_load),
        .pc_clear    (pc_clear),
        .ir_load     (ir_load),
        .addr_sel_pc (addr_sel_pc),
        .addr_load   (addr_load),
        .mem_cmd     (mem_cmd),
        .halted      (halted)
    );

    reg_file u_regs (
        .clk        (clk),
        .write      (reg_write),
        .reg_num    (reg_num),
        .write_data (wb_data),
        .read_data  (reg_data)
    );

    datapath u_dp (
        .clk         (clk),
        .reg_data    (reg_data),
        .shift       (shift),
        .alu_op      (op),
        .load_a      (load_a),
        .load_b      (load_b),
        .load_c      (load_c),
        .load_status (load_status),
        .asel_zero   (asel_zero),
        .bsel_imm    (bsel_imm),
        .sximm5      (sximm5),
        .sximm8      (sximm8),
        .mem_data    (read_data),
        .wb_sel      (wb_sel),
        .wb_data     (wb_data),
        .c_out       (c_out),
        .n           (n),
        .v           (v),
        .z           (z)
    );

endmodule

//--- logic/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    typedef enum logic [4:0] {
        ST_RESET,
        ST_FETCH_REQ,
        ST_FETCH_LOAD,
        ST_PC_INC,
        ST_DECODE,
        ST_MOV_IMM,
        ST_MOV_LOAD_B,
        ST_MOV_SHIFT,
        ST_MOV_WRITE,
        ST_ALU_LOAD_A,
        ST_ALU_LOAD_B,
        ST_ALU_EXEC,
        ST_ALU_WRITE,
        ST_CMP,
        ST_MVN_LOAD_B,
        ST_MVN_EXEC,
        ST_MVN_WRITE,
        ST_LDR_LOAD_A,
        ST_LDR_CALC,
        ST_LDR_ADDR,
        ST_LDR_WAIT,
        ST_LDR_WB,
        ST_STR_LOAD_A,
        ST_STR_CALC,
        ST_STR_ADDR,
        ST_STR_PASS,
        ST_STR_WRITE,
        ST_HALT
    } ctrl_state_t;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_READ  = 2'b01,
        MEM_WRITE = 2'b10
    } mem_cmd_t;

    typedef enum logic [1:0] {
        WB_C    = 2'b00,
        WB_IMM8 = 2'b01,
        WB_MEM  = 2'b10
    } wb_sel_t;

    typedef enum logic [1:0] {
        SEL_RN = 2'b00,
        SEL_RD = 2'b01,
        SEL_RM = 2'b10
    } reg_sel_t;

endpackage

//--- logic/cpu_isa_pkg.sv
package cpu_isa_pkg;

    localparam int WORD_W     = 16;
    localparam int MEM_ADDR_W = 9;
    localparam int NUM_REGS   = 8;

    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [MEM_ADDR_W-1:0]        addr_t;
    typedef logic [$clog2(NUM_REGS)-1:0]  reg_num_t;

    // instruction field positions
    localparam int OPC_MSB = 15;
    localparam int OPC_LSB = 13;
    localparam int OP_MSB  = 12;
    localparam int OP_LSB  = 11;
    localparam int RN_MSB  = 10;
    localparam int RN_LSB  = 8;
    localparam int RD_MSB  = 7;
    localparam int RD_LSB  = 5;
    localparam int SH_MSB  = 4;
    localparam int SH_LSB  = 3;
    localparam int RM_MSB  = 2;
    localparam int RM_LSB  = 0;
    localparam int IMM8_W  = 8;   // imm8 in [7:0]
    localparam int IMM5_W  = 5;   // imm5 in [4:0]

    typedef enum logic [2:0] {
        OPC_LDR  = 3'b011,
        OPC_STR  = 3'b100,
        OPC_ALU  = 3'b101,
        OPC_MOV  = 3'b110,
        OPC_HALT = 3'b111
    } opcode_t;

    typedef enum logic [1:0] {
        ALU_ADD   = 2'b00,
        ALU_SUB   = 2'b01,
        ALU_AND   = 2'b10,
        ALU_NOT_B = 2'b11
    } alu_op_t;

    // op field values under OPC_MOV
    localparam alu_op_t OP_MOV_IMM = ALU_AND;
    localparam alu_op_t OP_MOV_REG = ALU_ADD;

    typedef enum logic [1:0] {
        SH_NONE = 2'b00,
        SH_LSL1 = 2'b01,
        SH_LSR1 = 2'b10,   // zero fill
        SH_ASR1 = 2'b11    // sign fill
    } shift_t;

endpackage

//--- logic/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                  clk,
    input  cpu_isa_pkg::word_t    reg_data,
    input  cpu_isa_pkg::shift_t   shift,
    input  cpu_isa_pkg::alu_op_t  alu_op,
    input  logic                  load_a,
    input  logic                  load_b,
    input  logic                  load_c,
    input  logic                  load_status,
    input  logic                  asel_zero,
    input  logic                  bsel_imm,
    input  cpu_isa_pkg::word_t    sximm5,
    input  cpu_isa_pkg::word_t    sximm8,
    input  cpu_isa_pkg::word_t    mem_data,
    input  cpu_ctrl_pkg::wb_sel_t wb_sel,
    output cpu_isa_pkg::word_t    wb_data,
    output cpu_isa_pkg::word_t    c_out,
    output logic                  n,
    output logic                  v,
    output logic                  z
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    word_t a_reg;
    word_t b_reg;
    word_t c_reg;
    word_t b_shifted;
    word_t a_op;
    word_t b_op;
    word_t alu_out;
    logic  ovf;

    always_ff @(posedge clk) begin
        if (load_a) begin
            a_reg <= reg_data;
        end
        if (load_b) begin
            b_reg <= reg_data;
        end
        if (load_c) begin
            c_reg <= alu_out;
        end
        if (load_status) begin
            z <= (alu_out == '0);
            n <= alu_out[WORD_W-1];
            v <= ovf;
        end
    end

    always_comb begin
        case (shift)
            SH_LSL1: b_shifted = {b_reg[WORD_W-2:0], 1'b0};
            SH_LSR1: b_shifted = {1'b0, b_reg[WORD_W-1:1]};
            SH_ASR1: b_shifted = {b_reg[WORD_W-1], b_reg[WORD_W-1:1]};
            default: b_shifted = b_reg;
        endcase
    end

    assign a_op = asel_zero ? '0 : a_reg;
    assign b_op = bsel_imm ? sximm5 : b_shifted;

    always_comb begin
        ovf = 1'b0;
        case (alu_op)
            ALU_ADD: begin
                alu_out = a_op + b_op;
                ovf = (a_op[WORD_W-1] == b_op[WORD_W-1]) &&
                      (alu_out[WORD_W-1] != a_op[WORD_W-1]);
            end
            ALU_SUB: begin
                alu_out = a_op - b_op;
                ovf = (a_op[WORD_W-1] != b_op[WORD_W-1]) &&
                      (alu_out[WORD_W-1] != a_op[WORD_W-1]);
            end
            ALU_AND: alu_out = a_op & b_op;
            default: alu_out = ~b_op;
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_IMM8: wb_data = sximm8;
            WB_MEM:  wb_data = mem_data;
            default: wb_data = c_reg;
        endcase
    end

    assign c_out = c_reg;

    // status is only written by a cmp
    a_flags_hold: assert property (
        @(posedge clk) $changed({n, v, z}) |-> $past(load_status)
    );

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  cpu_isa_pkg::word_t     instr,
    input  cpu_ctrl_pkg::reg_sel_t reg_sel,
    output cpu_isa_pkg::opcode_t   opcode,
    output cpu_isa_pkg::alu_op_t   op,
    output cpu_isa_pkg::shift_t    shift,
    output cpu_isa_pkg::word_t     sximm8,
    output cpu_isa_pkg::word_t     sximm5,
    output cpu_isa_pkg::reg_num_t  reg_num
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    reg_num_t rn;
    reg_num_t rd;
    reg_num_t rm;

    assign rn = instr[RN_MSB:RN_LSB];
    assign rd = instr[RD_MSB:RD_LSB];
    assign rm = instr[RM_MSB:RM_LSB];

    assign opcode = opcode_t'(instr[OPC_MSB:OPC_LSB]);
    assign op     = alu_op_t'(instr[OP_MSB:OP_LSB]);

    // ldr/str use bits 4:3 as part of imm5, so no shift there
    assign shift = (opcode == OPC_LDR || opcode == OPC_STR) ? SH_NONE
                                                           : shift_t'(instr[SH_MSB:SH_LSB]);

    assign sximm8 = {{(WORD_W-IMM8_W){instr[IMM8_W-1]}}, instr[IMM8_W-1:0]};
    assign sximm5 = {{(WORD_W-IMM5_W){instr[IMM5_W-1]}}, instr[IMM5_W-1:0]};

    always_comb begin
        case (reg_sel)
            SEL_RN:  reg_num = rn;
            SEL_RD:  reg_num = rd;
            SEL_RM:  reg_num = rm;
            default: reg_num = rn;
        endcase
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  write,
    input  cpu_isa_pkg::reg_num_t reg_num,
    input  cpu_isa_pkg::word_t    write_data,
    output cpu_isa_pkg::word_t    read_data
);
    import cpu_isa_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (write) begin
            regs[reg_num] <= write_data;
        end
    end

    assign read_data = regs[reg_num];   // async read

endmodule
